//--- design/rv_pkg.sv
package rv_pkg;

    // RV32I major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    // ALU operations
    localparam logic [3:0] ALU_ADD   = 4'b0000;
    localparam logic [3:0] ALU_SUB   = 4'b0001;
    localparam logic [3:0] ALU_AND   = 4'b0010;
    localparam logic [3:0] ALU_OR    = 4'b0011;
    localparam logic [3:0] ALU_XOR   = 4'b0100;
    localparam logic [3:0] ALU_SLL   = 4'b0101;
    localparam logic [3:0] ALU_SRL   = 4'b0110;
    localparam logic [3:0] ALU_SRA   = 4'b0111;
    localparam logic [3:0] ALU_SLT   = 4'b1000;
    localparam logic [3:0] ALU_SLTU  = 4'b1001;
    localparam logic [3:0] ALU_LUI   = 4'b1010; // Immediate pass-through
    localparam logic [3:0] ALU_AUIPC = 4'b1011; // PC plus immediate

    // Branch conditions, same as branch funct3
    localparam logic [2:0] BR_EQ  = 3'b000;
    localparam logic [2:0] BR_NE  = 3'b001;
    localparam logic [2:0] BR_LT  = 3'b100;
    localparam logic [2:0] BR_GE  = 3'b101;
    localparam logic [2:0] BR_LTU = 3'b110;
    localparam logic [2:0] BR_GEU = 3'b111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One instruction word, six decodings
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_t;

endpackage

//--- design/ctrl_if.sv
`timescale 1ns/1ps

interface ctrl_if;
    logic       reg_write;
    logic       mem_to_reg;
    logic       mem_read;
    logic       mem_write;
    logic       alu_src;    // Operand B from immediate
    logic       branch;
    logic       jump;
    logic       jalr;       // Target from rs1 instead of pc
    logic [3:0] alu_op;
    logic [2:0] br_cond;

    modport ctrl (
        output reg_write, mem_to_reg, mem_read, mem_write, alu_src,
               branch, jump, jalr, alu_op, br_cond
    );

    modport exe (
        input reg_write, mem_to_reg, mem_read, mem_write, alu_src,
              branch, jump, jalr, alu_op, br_cond
    );
endinterface

//--- design/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  rv_pkg::instr_t instr,
    input  logic           imm_bit10,   // funct7[5] seen through the I immediate
    ctrl_if.ctrl           ctrl
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode = instr.i.opcode;
    assign funct3 = instr.i.funct3;

    // Datapath control levels
    always_comb begin
        ctrl.reg_write  = 1'b0;
        ctrl.mem_to_reg = 1'b0;
        ctrl.mem_read   = 1'b0;
        ctrl.mem_write  = 1'b0;
        ctrl.alu_src    = 1'b0;
        ctrl.branch     = 1'b0;
        ctrl.jump       = 1'b0;
        ctrl.jalr       = 1'b0;
        ctrl.br_cond    = BR_EQ;

        case (opcode)
            OPC_OP: begin
                ctrl.reg_write = 1'b1;
            end
            OPC_OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            OPC_LOAD: begin
                ctrl.reg_write  = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.mem_read   = 1'b1;
            end
            OPC_STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            OPC_BRANCH: begin
                ctrl.branch  = 1'b1;
                ctrl.br_cond = funct3; // Condition code is funct3
            end
            OPC_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
            end
            OPC_JALR: begin
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.jalr      = 1'b1;
            end
            OPC_LUI, OPC_AUIPC: begin
                ctrl.reg_write = 1'b1; // ALU op picks the immediate itself
            end
            default: ;
        endcase
    end

    // ALU operation select
    always_comb begin
        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                case (funct3)
                    3'b000: begin
                        // Only register form has SUB
                        if (opcode == OPC_OP && instr.r.funct7[5])
                            ctrl.alu_op = ALU_SUB;
                        else
                            ctrl.alu_op = ALU_ADD;
                    end
                    3'b001: ctrl.alu_op = ALU_SLL;
                    3'b010: ctrl.alu_op = ALU_SLT;
                    3'b011: ctrl.alu_op = ALU_SLTU;
                    3'b100: ctrl.alu_op = ALU_XOR;
                    3'b101: begin
                        if (opcode == OPC_OP)
                            ctrl.alu_op = instr.r.funct7[5] ? ALU_SRA : ALU_SRL;
                        else
                            ctrl.alu_op = imm_bit10 ? ALU_SRA : ALU_SRL;
                    end
                    3'b110: ctrl.alu_op = ALU_OR;
                    default: ctrl.alu_op = ALU_AND;
                endcase
            end
            OPC_LUI:   ctrl.alu_op = ALU_LUI;
            OPC_AUIPC: ctrl.alu_op = ALU_AUIPC;
            default:   ctrl.alu_op = ALU_ADD; // Address calculation
        endcase
    end
endmodule

//--- design/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
    input  rv_pkg::instr_t instr,
    output logic [31:0]    imm
);
    import rv_pkg::*;

    always_comb begin
        case (instr.r.opcode)
            OPC_OP_IMM, OPC_LOAD, OPC_JALR: begin
                imm = {{20{instr.i.imm[11]}}, instr.i.imm};
            end
            OPC_STORE: begin
                imm = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
            end
            OPC_BRANCH: begin
                imm = {{19{instr.b.imm_12}},
                       instr.b.imm_12,
                       instr.b.imm_11,
                       instr.b.imm_10_5,
                       instr.b.imm_4_1,
                       1'b0};           // Halfword aligned
            end
            OPC_LUI, OPC_AUIPC: begin
                imm = {instr.u.imm_31_12, 12'b0};
            end
            OPC_JAL: begin
                imm = {{11{instr.j.imm_20}},
                       instr.j.imm_20,
                       instr.j.imm_19_12,
                       instr.j.imm_11,
                       instr.j.imm_10_1,
                       1'b0};
            end
            default: begin
                imm = 32'b0; // R-type has no immediate
            end
        endcase
    end
endmodule

//--- design/alu_stage.sv
`timescale 1ns/1ps

module alu_stage (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        valid,
    input  logic [31:0] pc,
    input  logic [31:0] rs1_val,
    input  logic [31:0] rs2_val,
    input  logic [31:0] imm,
    ctrl_if.exe         ctrl,
    output logic        result_valid,
    output logic        reg_write,
    output logic        mem_to_reg,
    output logic        mem_read,
    output logic        mem_write,
    output logic        taken,
    output logic [31:0] alu_result,
    output logic [31:0] next_pc,
    output logic [31:0] store_data
);
    import rv_pkg::*;

    logic [31:0] op_b;
    logic [31:0] alu_out;
    logic [31:0] pc_plus4;
    logic [31:0] result_d;
    logic [31:0] next_pc_d;
    logic        cond_true;
    logic        taken_d;

    assign op_b     = ctrl.alu_src ? imm : rs2_val;
    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:   alu_out = rs1_val + op_b;
            ALU_SUB:   alu_out = rs1_val - op_b;
            ALU_AND:   alu_out = rs1_val & op_b;
            ALU_OR:    alu_out = rs1_val | op_b;
            ALU_XOR:   alu_out = rs1_val ^ op_b;
            ALU_SLL:   alu_out = rs1_val << op_b[4:0];
            ALU_SRL:   alu_out = rs1_val >> op_b[4:0];
            ALU_SRA:   alu_out = $signed(rs1_val) >>> op_b[4:0];
            ALU_SLT:   alu_out = {31'b0, $signed(rs1_val) < $signed(op_b)};
            ALU_SLTU:  alu_out = {31'b0, rs1_val < op_b};
            ALU_LUI:   alu_out = imm;
            ALU_AUIPC: alu_out = pc + imm;
            default:   alu_out = 32'b0;
        endcase
    end

    // Branch comparator, always on the two registers
    always_comb begin
        case (ctrl.br_cond)
            BR_EQ:   cond_true = (rs1_val == rs2_val);
            BR_NE:   cond_true = (rs1_val != rs2_val);
            BR_LT:   cond_true = ($signed(rs1_val) < $signed(rs2_val));
            BR_GE:   cond_true = ($signed(rs1_val) >= $signed(rs2_val));
            BR_LTU:  cond_true = (rs1_val < rs2_val);
            BR_GEU:  cond_true = (rs1_val >= rs2_val);
            default: cond_true = 1'b0;
        endcase
    end

    assign taken_d  = ctrl.jump | (ctrl.branch & cond_true);
    assign result_d = ctrl.jump ? pc_plus4 : alu_out; // Link value for jumps

    always_comb begin
        if (ctrl.jalr)
            next_pc_d = (rs1_val + imm) & 32'hffff_fffe;
        else if (taken_d)
            next_pc_d = pc + imm;
        else
            next_pc_d = pc_plus4;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            reg_write    <= 1'b0;
            mem_to_reg   <= 1'b0;
            mem_read     <= 1'b0;
            mem_write    <= 1'b0;
            taken        <= 1'b0;
            alu_result   <= 32'b0;
            next_pc      <= 32'b0;
            store_data   <= 32'b0;
        end else begin
            result_valid <= valid;
            reg_write    <= valid & ctrl.reg_write; // Controls drop on idle cycles
            mem_to_reg   <= valid & ctrl.mem_to_reg;
            mem_read     <= valid & ctrl.mem_read;
            mem_write    <= valid & ctrl.mem_write;
            taken        <= valid & taken_d;
            if (valid) begin
                alu_result <= result_d;
                next_pc    <= next_pc_d;
                store_data <= rs2_val;
            end
        end
    end
endmodule

//--- design/decode_exec_top.sv
`timescale 1ns/1ps

module decode_exec_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    input  logic [31:0] rs1_val,
    input  logic [31:0] rs2_val,
    output logic        result_valid,
    output logic        reg_write,
    output logic        mem_to_reg,
    output logic        mem_read,
    output logic        mem_write,
    output logic        taken,
    output logic [31:0] alu_result,
    output logic [31:0] next_pc,
    output logic [31:0] store_data
);

    logic [31:0] imm;

    ctrl_if ctrl_bus ();

    control_unit control_unit_i (
        .instr     (instr),
        .imm_bit10 (imm[10]), // SRAI versus SRLI
        .ctrl      (ctrl_bus.ctrl)
    );

    imm_gen imm_gen_i (
        .instr (instr),
        .imm   (imm)
    );

    alu_stage alu_stage_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid        (instr_valid),
        .pc           (pc),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .imm          (imm),
        .ctrl         (ctrl_bus.exe),
        .result_valid (result_valid),
        .reg_write    (reg_write),
        .mem_to_reg   (mem_to_reg),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .taken        (taken),
        .alu_result   (alu_result),
        .next_pc      (next_pc),
        .store_data   (store_data)
    );
endmodule

//--- testbench/decode_exec_properties.sv
`timescale 1ns/1ps

module decode_exec_properties (
    input logic clk,
    input logic rst_n,
    input logic instr_valid,
    input logic result_valid,
    input logic reg_write,
    input logic mem_to_reg,
    input logic mem_read,
    input logic mem_write,
    input logic taken
);
    // One result strobe per accepted instruction, exactly one cycle later
    strobe_follows_valid: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid == $past(instr_valid))
        else $error("result_valid does not follow instr_valid by one cycle");

    load_store_exclusive: assert property (@(posedge clk) !(mem_read && mem_write))
        else $error("mem_read and mem_write high together");

    // Registered controls stay cleared throughout reset
    controls_low_in_reset: assert property (@(posedge clk) !rst_n |->
        !(result_valid || reg_write || mem_to_reg || mem_read || mem_write || taken))
        else $error("control output high during reset");
endmodule

bind decode_exec_top decode_exec_properties decode_exec_properties_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .result_valid (result_valid),
    .reg_write    (reg_write),
    .mem_to_reg   (mem_to_reg),
    .mem_read     (mem_read),
    .mem_write    (mem_write),
    .taken        (taken)
);

//--- testbench/tb_decode_exec.sv
`timescale 1ns/1ps

module tb_decode_exec;
    import rv_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_INSTR    = 2000;
    localparam int TIMEOUT_NS   = (NUM_INSTR + 100 + RESET_CYCLES) * CLK_PERIOD;

    typedef struct packed {
        logic [6:0]  opcode;
        logic        reg_write;
        logic        mem_to_reg;
        logic        mem_read;
        logic        mem_write;
        logic        taken;
        logic [31:0] alu_result;
        logic [31:0] next_pc;
        logic [31:0] store_data;
    } expect_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic        result_valid;
    logic        reg_write;
    logic        mem_to_reg;
    logic        mem_read;
    logic        mem_write;
    logic        taken;
    logic [31:0] alu_result;
    logic [31:0] next_pc;
    logic [31:0] store_data;

    integer      seed = 32'h5a96_8a73;
    expect_t     exp_q[$];
    expect_t     cur;
    logic        pending_valid = 1'b0; // instr_valid seen one cycle earlier

    decode_exec_top decode_exec_top_i (.*);

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_on_failure();
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string test, input string field,
                                   input logic [31:0] exp, input logic [31:0] act);
        $display("FAILED %s %s: expected %h, actual %h", test, field, exp, act);
        stop_on_failure();
    endtask

    task automatic check_value(input string test, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else report_mismatch(test, field, exp, act);
    endtask

    task automatic check_flag(input string test, input string field,
                              input logic exp, input logic act);
        assert (act === exp) else report_mismatch(test, field, {31'b0, exp}, {31'b0, act});
    endtask

    // Every output back at zero
    task automatic check_reset_values();
        check_flag("reset", "result_valid", 1'b0, result_valid);
        check_flag("reset", "reg_write", 1'b0, reg_write);
        check_flag("reset", "mem_to_reg", 1'b0, mem_to_reg);
        check_flag("reset", "mem_read", 1'b0, mem_read);
        check_flag("reset", "mem_write", 1'b0, mem_write);
        check_flag("reset", "taken", 1'b0, taken);
        check_value("reset", "alu_result", 32'd0, alu_result);
        check_value("reset", "next_pc", 32'd0, next_pc);
        check_value("reset", "store_data", 32'd0, store_data);
    endtask

    function automatic string op_name(input logic [6:0] opc);
        case (opc)
            OPC_OP:     return "OP";
            OPC_OP_IMM: return "OP_IMM";
            OPC_LOAD:   return "LOAD";
            OPC_STORE:  return "STORE";
            OPC_BRANCH: return "BRANCH";
            OPC_JAL:    return "JAL";
            OPC_JALR:   return "JALR";
            OPC_LUI:    return "LUI";
            default:    return "AUIPC";
        endcase
    endfunction

    // Random legal instruction, fields fixed up per format
    task automatic build_instr(output logic [31:0] word);
        int         sel;
        logic [2:0] f3;
        word = $random(seed);
        sel  = $unsigned($random(seed)) % 9;
        f3   = word[14:12];
        case (sel)
            0: begin
                word[6:0] = OPC_OP;
                if (f3 == 3'd0 || f3 == 3'd5)
                    word[31:25] = word[31] ? 7'h20 : 7'h00; // SUB or SRA
                else
                    word[31:25] = 7'h00;
            end
            1: begin
                word[6:0] = OPC_OP_IMM;
                if (f3 == 3'd1)
                    word[31:25] = 7'h00;
                else if (f3 == 3'd5)
                    word[31:25] = word[31] ? 7'h20 : 7'h00;
            end
            2: word[6:0] = OPC_LOAD;
            3: word[6:0] = OPC_STORE;
            4: begin
                word[6:0] = OPC_BRANCH;
                if (f3 == 3'd2 || f3 == 3'd3)
                    word[14:12] = f3 + 3'd2; // No branch uses 010 or 011
            end
            5: word[6:0] = OPC_JAL;
            6: begin
                word[6:0]   = OPC_JALR;
                word[14:12] = 3'b000;
            end
            7: word[6:0] = OPC_LUI;
            default: word[6:0] = OPC_AUIPC;
        endcase
    endtask

    // Reference model built from the RV32I encoding
    function automatic expect_t expected_result(input logic [31:0] w, input logic [31:0] pcv,
                                                input logic [31:0] rs1, input logic [31:0] rs2);
        expect_t     e;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [31:0] imm;
        logic [31:0] b;
        logic        cond;
        opc = w[6:0];
        f3  = w[14:12];
        case (opc)
            OPC_OP_IMM, OPC_LOAD, OPC_JALR: imm = {{20{w[31]}}, w[31:20]};
            OPC_STORE:          imm = {{20{w[31]}}, w[31:25], w[11:7]};
            OPC_BRANCH:         imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC: imm = {w[31:12], 12'h000};
            OPC_JAL:            imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default:            imm = 32'd0;
        endcase
        b = (opc == OPC_OP || opc == OPC_BRANCH) ? rs2 : imm;
        e.opcode     = opc;
        e.reg_write  = !(opc == OPC_STORE || opc == OPC_BRANCH);
        e.mem_to_reg = (opc == OPC_LOAD);
        e.mem_read   = (opc == OPC_LOAD);
        e.mem_write  = (opc == OPC_STORE);
        e.store_data = rs2;
        if (opc == OPC_OP || opc == OPC_OP_IMM) begin
            case (f3)
                3'd0: e.alu_result = (opc == OPC_OP && w[30]) ? rs1 - b : rs1 + b;
                3'd1: e.alu_result = rs1 << b[4:0];
                3'd2: e.alu_result = ($signed(rs1) < $signed(b)) ? 32'd1 : 32'd0;
                3'd3: e.alu_result = (rs1 < b) ? 32'd1 : 32'd0;
                3'd4: e.alu_result = rs1 ^ b;
                3'd5: begin
                    if (w[30])
                        e.alu_result = $signed(rs1) >>> b[4:0];
                    else
                        e.alu_result = rs1 >> b[4:0];
                end
                3'd6: e.alu_result = rs1 | b;
                default: e.alu_result = rs1 & b;
            endcase
        end else if (opc == OPC_LUI) begin
            e.alu_result = imm;
        end else if (opc == OPC_AUIPC) begin
            e.alu_result = pcv + imm;
        end else if (opc == OPC_JAL || opc == OPC_JALR) begin
            e.alu_result = pcv + 32'd4; // Link value
        end else begin
            e.alu_result = rs1 + b;
        end
        case (f3)
            3'b000:  cond = (rs1 == rs2);
            3'b001:  cond = (rs1 != rs2);
            3'b100:  cond = ($signed(rs1) < $signed(rs2));
            3'b101:  cond = ($signed(rs1) >= $signed(rs2));
            3'b110:  cond = (rs1 < rs2);
            default: cond = (rs1 >= rs2);
        endcase
        e.taken = (opc == OPC_JAL) || (opc == OPC_JALR) || (opc == OPC_BRANCH && cond);
        if (opc == OPC_JALR)
            e.next_pc = (rs1 + imm) & 32'hffff_fffe;
        else if (e.taken)
            e.next_pc = pcv + imm;
        else
            e.next_pc = pcv + 32'd4;
        return e;
    endfunction

    // Outputs are compared away from the driving edge
    always @(negedge clk) begin
        check_flag("strobe", "result_valid", pending_valid, result_valid);
        if (result_valid) begin
            cur = exp_q.pop_front();
            check_flag(op_name(cur.opcode), "reg_write", cur.reg_write, reg_write);
            check_flag(op_name(cur.opcode), "mem_to_reg", cur.mem_to_reg, mem_to_reg);
            check_flag(op_name(cur.opcode), "mem_read", cur.mem_read, mem_read);
            check_flag(op_name(cur.opcode), "mem_write", cur.mem_write, mem_write);
            check_flag(op_name(cur.opcode), "taken", cur.taken, taken);
            check_value(op_name(cur.opcode), "alu_result", cur.alu_result, alu_result);
            check_value(op_name(cur.opcode), "next_pc", cur.next_pc, next_pc);
            check_value(op_name(cur.opcode), "store_data", cur.store_data, store_data);
        end else begin
            check_flag("idle", "reg_write", 1'b0, reg_write);
            check_flag("idle", "mem_read", 1'b0, mem_read);
            check_flag("idle", "mem_write", 1'b0, mem_write);
        end
        pending_valid = instr_valid;
        if (instr_valid)
            exp_q.push_back(expected_result(instr, pc, rs1_val, rs2_val));
    end

    initial begin
        logic [31:0] word;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] rnd;
        rst_n       <= 1'b0;
        instr_valid <= 1'b0;
        instr       <= 32'd0;
        pc          <= 32'd0;
        rs1_val     <= 32'd0;
        rs2_val     <= 32'd0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_reset_values();
        for (int n = 0; n < NUM_INSTR; n++) begin
            @(posedge clk);
            build_instr(word);
            a   = $random(seed);
            b   = $random(seed);
            rnd = $random(seed);
            instr_valid <= (($random(seed) & 3) != 0); // About 75 percent busy
            instr       <= word;
            pc          <= {rnd[31:2], 2'b00};
            rs1_val     <= a;
            rs2_val     <= (($random(seed) & 7) == 0) ? a : b; // Equal operands now and then
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b0; // Outputs still hold the last result here
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_reset_values();
        $display("Done: no errors");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Run timed out after %0d ns before the stimulus completed", TIMEOUT_NS);
        stop_on_failure();
    end
endmodule

//--- project.f
design/rv_pkg.sv
design/ctrl_if.sv
design/control_unit.sv
design/imm_gen.sv
design/alu_stage.sv
design/decode_exec_top.sv
testbench/decode_exec_properties.sv
testbench/tb_decode_exec.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_decode_exec
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Done: no errors

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
